//--- build.f
+incdir+hw
hw/cpu_pkg.sv
hw/regfile.sv
hw/pipe_reg.sv
hw/instr_exec.sv
hw/instr_fetch.sv
hw/decode_and_issue.sv
hw/cpu_core.sv
verif/cpu_core_assert.sv
verif/cpu_core_tb.sv

//--- hw/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// lanes issued per cycle
`define ISSUE_NUM 2

// general purpose registers
`define REG_NUM 32

// instruction words buffered between fetch and decode
`define INSTR_FIFO_DEPTH 8

`endif

//--- hw/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core import cpu_pkg::*; (
	input  logic                           clk,
	input  logic                           rst,
	output logic                           ibus_read,
	output virt_t                          ibus_address,
	input  logic [63:0]                    ibus_rddata,
	input  logic                           ibus_stall,
	output logic      [`ISSUE_NUM-1:0]     debug_wb_valid,
	output reg_addr_t [`ISSUE_NUM-1:0]     debug_wb_waddr,
	output uint32_t   [`ISSUE_NUM-1:0]     debug_wb_wdata
);

// no branch or memory stage, so nothing flushes or stalls
logic flush_id, stall_id;
logic flush_ex, stall_ex;
logic stall_wb;

assign flush_id = 1'b0;
assign stall_id = 1'b0;
assign flush_ex = 1'b0;
assign stall_ex = 1'b0;
assign stall_wb = 1'b0;

logic      [`ISSUE_NUM-1:0]   reg_we;
reg_addr_t [`ISSUE_NUM-1:0]   reg_waddr;
uint32_t   [`ISSUE_NUM-1:0]   reg_wdata;
reg_addr_t [2*`ISSUE_NUM-1:0] reg_raddr;
uint32_t   [2*`ISSUE_NUM-1:0] reg_rdata;

fetch_ack_t                      if_fetch_ack;
fetch_entry_t [`ISSUE_NUM-1:0]   if_fetch_entry;

pipeline_decode_t [`ISSUE_NUM-1:0] pipeline_decode, pipeline_decode_d;
pipeline_exec_t   [`ISSUE_NUM-1:0] pipeline_exec, pipeline_wb;

instr_fetch #(
	.INSTR_FIFO_DEPTH ( `INSTR_FIFO_DEPTH )
) instr_fetch_inst (
	.clk,
	.rst,
	.ibus_read,
	.ibus_address,
	.ibus_rddata,
	.ibus_stall,
	.fetch_ack   ( if_fetch_ack   ),
	.fetch_entry ( if_fetch_entry )
);

decode_and_issue decode_issue_inst (
	.fetch_entry     ( if_fetch_entry  ),
	.issue_num       ( if_fetch_ack    ),
	.reg_raddr,
	.reg_rdata,
	.pipeline_exec,
	.pipeline_wb,
	.pipeline_decode
);

pipe_reg #(
	.T     ( pipeline_decode_t ),
	.LANES ( `ISSUE_NUM        )
) id_ex_reg (
	.clk,
	.rst,
	.flush      ( flush_id          ),
	.stall      ( stall_id          ),
	.stall_next ( stall_ex          ),
	.d          ( pipeline_decode   ),
	.q          ( pipeline_decode_d )
);

for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_exec
	instr_exec exec_inst (
		.data   ( pipeline_decode_d[i] ),
		.result ( pipeline_exec[i]     )
	);
end

pipe_reg #(
	.T     ( pipeline_exec_t ),
	.LANES ( `ISSUE_NUM      )
) ex_wb_reg (
	.clk,
	.rst,
	.flush      ( flush_ex      ),
	.stall      ( stall_ex      ),
	.stall_next ( stall_wb      ),
	.d          ( pipeline_exec ),
	.q          ( pipeline_wb   )
);

// write back and trace
for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_write_back
	assign reg_we[i]         = pipeline_wb[i].valid;
	assign reg_waddr[i]      = pipeline_wb[i].rd;
	assign reg_wdata[i]      = pipeline_wb[i].wdata;
	assign debug_wb_valid[i] = pipeline_wb[i].valid && (pipeline_wb[i].rd != '0);
	assign debug_wb_waddr[i] = pipeline_wb[i].rd;
	assign debug_wb_wdata[i] = pipeline_wb[i].wdata;
end

regfile #(
	.REG_NUM     ( `REG_NUM       ),
	.DATA_WIDTH  ( 32             ),
	.WRITE_PORTS ( `ISSUE_NUM     ),
	.READ_PORTS  ( 2*`ISSUE_NUM   ),
	.ZERO_KEEP   ( 1              )
) regfile_inst (
	.clk,
	.rst,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;
typedef logic [31:0] virt_t;

// zero value is the nop, so a cleared payload is a bubble
typedef enum logic [3:0] {
	OP_NOP,
	OP_ADDU,
	OP_SUBU,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_SLT,
	OP_SLTU,
	OP_ADDIU,
	OP_ANDI,
	OP_ORI,
	OP_LUI
} alu_op_t;

typedef struct packed {
	logic    valid;
	uint32_t instr;
	virt_t   vaddr;
} fetch_entry_t;

// entries consumed by decode, 0 to 2
typedef logic [1:0] fetch_ack_t;

// operand b already holds the extended immediate when one is used
typedef struct packed {
	logic      valid;
	alu_op_t   alu_op;
	uint32_t   a;
	uint32_t   b;
	reg_addr_t rd;
} pipeline_decode_t;

// rd of 0 writes nothing
typedef struct packed {
	logic      valid;
	reg_addr_t rd;
	uint32_t   wdata;
} pipeline_exec_t;

endpackage

//--- hw/decode_and_issue.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_and_issue import cpu_pkg::*; (
	input  fetch_entry_t     [`ISSUE_NUM-1:0]   fetch_entry,
	output fetch_ack_t                          issue_num,
	output reg_addr_t        [2*`ISSUE_NUM-1:0] reg_raddr,
	input  uint32_t          [2*`ISSUE_NUM-1:0] reg_rdata,
	input  pipeline_exec_t   [`ISSUE_NUM-1:0]   pipeline_exec,
	input  pipeline_exec_t   [`ISSUE_NUM-1:0]   pipeline_wb,
	output pipeline_decode_t [`ISSUE_NUM-1:0]   pipeline_decode
);

alu_op_t   [`ISSUE_NUM-1:0] op;
reg_addr_t [`ISSUE_NUM-1:0] rs, rt, dst;
uint32_t   [`ISSUE_NUM-1:0] imm;
uint32_t   [`ISSUE_NUM-1:0] fwd_rs, fwd_rt;
logic      [`ISSUE_NUM-1:0] use_rs, use_rt, use_imm;
logic      [`ISSUE_NUM-1:0] issue_lane;
logic                       dep;

// anything unrecognized, including the zero word, is a nop
function automatic alu_op_t decode_op(input uint32_t instr);
	alu_op_t res;
	res = OP_NOP;
	case (instr[31:26])
		6'h00: begin
			case (instr[5:0])
				6'h21: res = OP_ADDU;
				6'h23: res = OP_SUBU;
				6'h24: res = OP_AND;
				6'h25: res = OP_OR;
				6'h26: res = OP_XOR;
				6'h2a: res = OP_SLT;
				6'h2b: res = OP_SLTU;
				default: res = OP_NOP;
			endcase
		end
		6'h09: res = OP_ADDIU;
		6'h0c: res = OP_ANDI;
		6'h0d: res = OP_ORI;
		6'h0f: res = OP_LUI;
		default: res = OP_NOP;
	endcase
	return res;
endfunction

// EX over WB, lane 1 over lane 0
function automatic uint32_t forward(
	input reg_addr_t                        addr,
	input uint32_t                          rf_value,
	input pipeline_exec_t [`ISSUE_NUM-1:0]  ex,
	input pipeline_exec_t [`ISSUE_NUM-1:0]  wb
);
	uint32_t value;
	value = rf_value;
	for (int i = 0; i < `ISSUE_NUM; i++)
		if (wb[i].valid && wb[i].rd == addr)
			value = wb[i].wdata;
	for (int i = 0; i < `ISSUE_NUM; i++)
		if (ex[i].valid && ex[i].rd == addr)
			value = ex[i].wdata;
	if (addr == '0)
		value = '0;
	return value;
endfunction

always_comb begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		op[i]      = decode_op(fetch_entry[i].instr);
		rs[i]      = fetch_entry[i].instr[25:21];
		rt[i]      = fetch_entry[i].instr[20:16];
		use_rs[i]  = 1'b0;
		use_rt[i]  = 1'b0;
		use_imm[i] = 1'b0;
		dst[i]     = '0;
		imm[i]     = '0;
		case (op[i])
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU: begin
				use_rs[i] = 1'b1;
				use_rt[i] = 1'b1;
				dst[i]    = fetch_entry[i].instr[15:11];
			end
			OP_ADDIU: begin
				use_rs[i]  = 1'b1;
				use_imm[i] = 1'b1;
				dst[i]     = rt[i];
				imm[i]     = {{16{fetch_entry[i].instr[15]}}, fetch_entry[i].instr[15:0]};
			end
			OP_ANDI, OP_ORI: begin
				use_rs[i]  = 1'b1;
				use_imm[i] = 1'b1;
				dst[i]     = rt[i];
				imm[i]     = {16'h0, fetch_entry[i].instr[15:0]};
			end
			OP_LUI: begin
				use_imm[i] = 1'b1;
				dst[i]     = rt[i];
				imm[i]     = {fetch_entry[i].instr[15:0], 16'h0};
			end
			default: ;
		endcase
	end
end

// second of the pair waits if it reads what the first writes
assign dep = (dst[0] != '0)
	&& ((use_rs[1] && rs[1] == dst[0]) || (use_rt[1] && rt[1] == dst[0]));

assign issue_lane[0] = fetch_entry[0].valid;
assign issue_lane[1] = fetch_entry[0].valid && fetch_entry[1].valid && !dep;
assign issue_num     = issue_lane[1] ? 2'd2 : (issue_lane[0] ? 2'd1 : 2'd0);

always_comb begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		reg_raddr[2*i]     = rs[i];
		reg_raddr[2*i + 1] = rt[i];
		fwd_rs[i] = forward(rs[i], reg_rdata[2*i], pipeline_exec, pipeline_wb);
		fwd_rt[i] = forward(rt[i], reg_rdata[2*i + 1], pipeline_exec, pipeline_wb);
		pipeline_decode[i] = '0;
		if (issue_lane[i]) begin
			pipeline_decode[i].valid  = 1'b1;
			pipeline_decode[i].alu_op = op[i];
			pipeline_decode[i].a      = fwd_rs[i];
			pipeline_decode[i].b      = use_imm[i] ? imm[i] : fwd_rt[i];
			pipeline_decode[i].rd     = dst[i];
		end
	end
end

endmodule

//--- hw/instr_exec.sv
`timescale 1ns/1ps

module instr_exec import cpu_pkg::*; (
	input  pipeline_decode_t data,
	output pipeline_exec_t   result
);

always_comb begin
	result.valid = data.valid;
	result.rd    = data.rd;
	result.wdata = '0;
	case (data.alu_op)
		// wrapping add, no overflow trap
		OP_ADDU, OP_ADDIU: result.wdata = data.a + data.b;
		OP_SUBU:           result.wdata = data.a - data.b;
		OP_AND, OP_ANDI:   result.wdata = data.a & data.b;
		OP_OR, OP_ORI:     result.wdata = data.a | data.b;
		OP_XOR:            result.wdata = data.a ^ data.b;
		OP_SLT: begin
			result.wdata = {31'h0, $signed(data.a) < $signed(data.b)};
		end
		OP_SLTU: begin
			result.wdata = {31'h0, data.a < data.b};
		end
		// immediate comes in already shifted
		OP_LUI:            result.wdata = data.b;
		default: begin
			result.rd = '0;
		end
	endcase
end

endmodule

//--- hw/instr_fetch.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_fetch import cpu_pkg::*; #(
	parameter int INSTR_FIFO_DEPTH = `INSTR_FIFO_DEPTH
) (
	input  logic                          clk,
	input  logic                          rst,
	output logic                          ibus_read,
	output virt_t                         ibus_address,
	input  logic [63:0]                   ibus_rddata,
	input  logic                          ibus_stall,
	input  fetch_ack_t                    fetch_ack,
	output fetch_entry_t [`ISSUE_NUM-1:0] fetch_entry
);

localparam int PTR_W = $clog2(INSTR_FIFO_DEPTH);

logic [PTR_W-1:0] wr_ptr, wr_ptr_nx;
logic [PTR_W-1:0] rd_ptr, rd_ptr_nx;
logic [PTR_W:0]   count;
logic [PTR_W:0]   push_cnt, pop_cnt;
logic             running;
logic             push;
virt_t            pc;

uint32_t fifo_instr [INSTR_FIFO_DEPTH];
virt_t   fifo_addr  [INSTR_FIFO_DEPTH];

// request only with room for a whole pair
assign ibus_read    = running && (count <= (PTR_W + 1)'(INSTR_FIFO_DEPTH - 2));
assign ibus_address = pc;
assign push         = ibus_read && !ibus_stall;

assign wr_ptr_nx = wr_ptr + PTR_W'(1);
assign rd_ptr_nx = rd_ptr + PTR_W'(1);
assign push_cnt  = push ? (PTR_W + 1)'(2) : '0;
assign pop_cnt   = (PTR_W + 1)'(fetch_ack);

always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		running <= 1'b0;
		pc      <= '0;
		wr_ptr  <= '0;
		rd_ptr  <= '0;
		count   <= '0;
	end else begin
		running <= 1'b1;
		if (push) begin
			pc     <= pc + 32'd8;
			wr_ptr <= wr_ptr + PTR_W'(2);
		end
		rd_ptr <= rd_ptr + PTR_W'(fetch_ack);
		count  <= count + push_cnt - pop_cnt;
	end
end

// lower word at the pair address, upper word 4 above
always_ff @(posedge clk) begin
	if (push) begin
		fifo_instr[wr_ptr]    <= ibus_rddata[31:0];
		fifo_addr[wr_ptr]     <= pc;
		fifo_instr[wr_ptr_nx] <= ibus_rddata[63:32];
		fifo_addr[wr_ptr_nx]  <= pc + 32'd4;
	end
end

always_comb begin
	fetch_entry[0].valid = (count != '0);
	fetch_entry[0].instr = fifo_instr[rd_ptr];
	fetch_entry[0].vaddr = fifo_addr[rd_ptr];
	fetch_entry[1].valid = (count >= (PTR_W + 1)'(2));
	fetch_entry[1].instr = fifo_instr[rd_ptr_nx];
	fetch_entry[1].vaddr = fifo_addr[rd_ptr_nx];
end

endmodule

//--- hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type T     = logic [31:0],
	parameter int  LANES = 2
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           flush,
	input  logic           stall,
	input  logic           stall_next,
	input  T [LANES-1:0]   d,
	output T [LANES-1:0]   q
);

// a bubble goes on when this stage holds but the next one moves on
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		q <= '0;
	end else if (flush || (stall && !stall_next)) begin
		q <= '0;
	end else if (!stall) begin
		q <= d;
	end
end

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile #(
	parameter int REG_NUM     = 32,
	parameter int DATA_WIDTH  = 32,
	parameter int WRITE_PORTS = 2,
	parameter int READ_PORTS  = 4,
	parameter bit ZERO_KEEP   = 1,
	localparam int ADDR_W     = $clog2(REG_NUM)
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic [WRITE_PORTS-1:0]                 we,
	input  logic [WRITE_PORTS-1:0][ADDR_W-1:0]     waddr,
	input  logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0] wdata,
	input  logic [READ_PORTS-1:0][ADDR_W-1:0]      raddr,
	output logic [READ_PORTS-1:0][DATA_WIDTH-1:0]  rdata
);

logic [DATA_WIDTH-1:0] regs [REG_NUM];

// later ports are written last and win on equal addresses
always_ff @(posedge clk or posedge rst) begin
	if (rst) begin
		for (int i = 0; i < REG_NUM; i++)
			regs[i] <= '0;
	end else begin
		for (int w = 0; w < WRITE_PORTS; w++)
			if (we[w] && !(ZERO_KEEP && waddr[w] == '0))
				regs[waddr[w]] <= wdata[w];
	end
end

// no bypass, the caller forwards
always_comb begin
	for (int r = 0; r < READ_PORTS; r++)
		rdata[r] = (ZERO_KEEP && raddr[r] == '0) ? '0 : regs[raddr[r]];
end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds and runs the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module cpu_core_tb \
	-f build.f \
	-o cpu_core_sim

./obj_dir/cpu_core_sim | tee sim.log

# the run counts as good only if the log holds the pass line
grep -q "^Testbench passed$" sim.log

//--- verif/cpu_core_assert.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core_assert import cpu_pkg::*; (
	input logic                          clk,
	input logic                          rst,
	input logic                          ibus_read,
	input virt_t                         ibus_address,
	input logic                          ibus_stall,
	input fetch_ack_t                    issue_num,
	input fetch_entry_t [`ISSUE_NUM-1:0] fetch_entry,
	input logic [`ISSUE_NUM-1:0]         debug_wb_valid,
	input reg_addr_t [`ISSUE_NUM-1:0]    debug_wb_waddr
);

logic [`ISSUE_NUM-1:0] entry_valid;

for (genvar i = 0; i < `ISSUE_NUM; ++i) begin : gen_lane
	assign entry_valid[i] = fetch_entry[i].valid;

	a_no_zero_reg: assert property (@(posedge clk) disable iff (rst)
		debug_wb_valid[i] |-> debug_wb_waddr[i] != '0)
		else $error("trace lane %0d shows register 0", i);
end

a_quiet_in_reset: assert property (@(posedge clk) rst |-> debug_wb_valid == '0)
	else $error("trace valid while in reset");

// a stalled request keeps its address
a_addr_held: assert property (@(posedge clk) disable iff (rst)
	ibus_read && ibus_stall |=> $stable(ibus_address))
	else $error("ibus_address moved during a stalled read");

a_issue_bound: assert property (@(posedge clk) disable iff (rst)
	int'(issue_num) <= $countones(entry_valid))
	else $error("issue count above the valid fetch entries");

endmodule

bind cpu_core cpu_core_assert u_cpu_core_assert (
	.clk,
	.rst,
	.ibus_read,
	.ibus_address,
	.ibus_stall,
	.issue_num      ( if_fetch_ack   ),
	.fetch_entry    ( if_fetch_entry ),
	.debug_wb_valid,
	.debug_wb_waddr
);

//--- verif/cpu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core_tb import cpu_pkg::*; ();

localparam int MEM_PAIRS     = 32;
localparam int NUM_SEG       = 5;
localparam int ENTRY_TIMEOUT = 100;
localparam int DRAIN_CYCLES  = 30;

// MIPS32 opcode and funct fields
localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_ADDIU   = 6'h09;
localparam logic [5:0] OPC_ANDI    = 6'h0c;
localparam logic [5:0] OPC_ORI     = 6'h0d;
localparam logic [5:0] OPC_LUI     = 6'h0f;
localparam logic [5:0] FN_ADDU     = 6'h21;
localparam logic [5:0] FN_SUBU     = 6'h23;
localparam logic [5:0] FN_AND      = 6'h24;
localparam logic [5:0] FN_OR       = 6'h25;
localparam logic [5:0] FN_XOR      = 6'h26;
localparam logic [5:0] FN_SLT      = 6'h2a;
localparam logic [5:0] FN_SLTU     = 6'h2b;

logic                          clk        = 1'b0;
logic                          rst        = 1'b1;
logic                          ibus_stall = 1'b0;
logic                          ibus_read;
virt_t                         ibus_address;
logic [63:0]                   ibus_rddata;
logic      [`ISSUE_NUM-1:0]    debug_wb_valid;
reg_addr_t [`ISSUE_NUM-1:0]    debug_wb_waddr;
uint32_t   [`ISSUE_NUM-1:0]    debug_wb_wdata;

int        seed       = 32'h7b4a_a307;
virt_t     stall_from = '1;
virt_t     fetch_addr_exp = '0;
uint32_t   imem [2*MEM_PAIRS];
logic [28:0] pair_idx;
uint32_t   prog_word [$];
int        prog_seg [$];
int        exp_rd [$];
uint32_t   exp_data [$];
int        exp_seg [$];
reg_addr_t got_rd [$];
uint32_t   got_data [$];
string     seg_name [NUM_SEG] = '{"alu ops", "pair dependency", "forwarding",
	"register zero and nops", "random stall"};
int        checks;
int        errors;
int        next_exp;
int        seg_count;
int        seg_errors;
bit        aborted;
bit        found;

cpu_core u_cpu_core (
	.clk,
	.rst,
	.ibus_read,
	.ibus_address,
	.ibus_rddata,
	.ibus_stall,
	.debug_wb_valid,
	.debug_wb_waddr,
	.debug_wb_wdata
);

initial begin
	forever #5 clk = ~clk;
end

// instruction memory, zero outside the program
assign pair_idx = ibus_address[31:3];
always_comb begin
	if (pair_idx < 29'(MEM_PAIRS))
		ibus_rddata = {imem[{pair_idx[4:0], 1'b1}], imem[{pair_idx[4:0], 1'b0}]};
	else
		ibus_rddata = '0;
end

// stalls only once fetch reaches the last segment
always @(posedge clk) begin
	if (!rst && ibus_address >= stall_from)
		ibus_stall <= ($unsigned($random(seed)) % 32'd3) == 32'd0;
	else
		ibus_stall <= 1'b0;
end

task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
		errors++;
	end
endtask

function automatic uint32_t r_type(input logic [5:0] funct, input int d, input int s, input int t);
	return {OPC_SPECIAL, 5'(s), 5'(t), 5'(d), 5'h00, funct};
endfunction

function automatic uint32_t i_type(input logic [5:0] opc, input int t, input int s,
	input logic [15:0] imm);
	return {opc, 5'(s), 5'(t), imm};
endfunction

task automatic add_instr(input int seg, input uint32_t word);
	prog_word.push_back(word);
	prog_seg.push_back(seg);
endtask

task automatic load_program();
	add_instr(0, i_type(OPC_LUI, 1, 0, 16'h8000));
	add_instr(0, i_type(OPC_ORI, 2, 0, 16'h1234));
	add_instr(0, i_type(OPC_LUI, 3, 0, 16'h1234));
	add_instr(0, i_type(OPC_ADDIU, 4, 0, 16'hfffb));
	add_instr(0, i_type(OPC_ORI, 3, 3, 16'h5678));
	add_instr(0, i_type(OPC_ANDI, 5, 4, 16'h00f0));
	add_instr(0, r_type(FN_ADDU, 6, 1, 2));
	add_instr(0, r_type(FN_SUBU, 7, 2, 4));
	add_instr(0, r_type(FN_AND, 8, 4, 3));
	add_instr(0, r_type(FN_OR, 9, 1, 2));
	add_instr(0, r_type(FN_XOR, 10, 3, 4));
	add_instr(0, r_type(FN_SLT, 11, 1, 2));
	add_instr(0, r_type(FN_SLTU, 12, 1, 2));
	add_instr(0, r_type(FN_SLT, 13, 2, 4));
	add_instr(0, r_type(FN_SLTU, 14, 2, 4));
	add_instr(0, i_type(OPC_ADDIU, 15, 1, 16'hffff));
	// each second word reads the first one's result
	add_instr(1, i_type(OPC_ADDIU, 16, 0, 16'd100));
	add_instr(1, r_type(FN_ADDU, 17, 16, 16));
	add_instr(1, r_type(FN_SUBU, 18, 17, 16));
	add_instr(1, r_type(FN_XOR, 19, 18, 17));
	add_instr(1, i_type(OPC_LUI, 20, 0, 16'habcd));
	add_instr(1, i_type(OPC_ORI, 20, 20, 16'hef01));
	add_instr(2, i_type(OPC_ADDIU, 23, 0, 16'd1));
	add_instr(2, i_type(OPC_ADDIU, 24, 0, 16'd2));
	add_instr(2, r_type(FN_ADDU, 23, 23, 24));
	add_instr(2, r_type(FN_ADDU, 25, 24, 24));
	add_instr(2, r_type(FN_ADDU, 26, 23, 25));
	add_instr(2, r_type(FN_SUBU, 27, 24, 0));
	add_instr(2, r_type(FN_XOR, 28, 23, 26));
	add_instr(2, r_type(FN_AND, 29, 28, 27));
	add_instr(3, i_type(OPC_ADDIU, 0, 0, 16'd55));
	add_instr(3, 32'h0000_0000);
	add_instr(3, r_type(FN_ADDU, 1, 0, 0));
	add_instr(3, 32'hffff_ffff);
	add_instr(3, i_type(OPC_ORI, 0, 2, 16'hffff));
	add_instr(3, r_type(FN_OR, 3, 0, 2));
	// lw is outside the supported set
	add_instr(3, 32'h8c04_0000);
	add_instr(3, r_type(FN_ADDU, 5, 4, 0));
	add_instr(4, i_type(OPC_ADDIU, 6, 0, 16'h0101));
	add_instr(4, r_type(FN_ADDU, 7, 6, 6));
	add_instr(4, i_type(OPC_LUI, 8, 0, 16'hffff));
	add_instr(4, r_type(FN_OR, 9, 8, 7));
	add_instr(4, r_type(FN_SLT, 10, 9, 0));
	add_instr(4, r_type(FN_SLTU, 11, 0, 9));
	add_instr(4, r_type(FN_SUBU, 12, 10, 11));
	add_instr(4, r_type(FN_XOR, 13, 9, 6));
	add_instr(4, i_type(OPC_ANDI, 14, 13, 16'hff00));
	add_instr(4, r_type(FN_ADDU, 15, 14, 13));
endtask

// sequential reference model of the supported instructions
task automatic build_expected();
	uint32_t regs [32];
	uint32_t w;
	uint32_t a;
	uint32_t b;
	uint32_t res;
	int      dst;
	bit      writes;
	foreach (regs[r])
		regs[r] = '0;
	for (int n = 0; n < prog_word.size(); n++) begin
		w      = prog_word[n];
		a      = regs[w[25:21]];
		b      = regs[w[20:16]];
		dst    = int'(w[20:16]);
		writes = 1'b1;
		res    = '0;
		case (w[31:26])
			OPC_SPECIAL: begin
				dst = int'(w[15:11]);
				case (w[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			OPC_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
			OPC_ANDI:  res = a & {16'h0, w[15:0]};
			OPC_ORI:   res = a | {16'h0, w[15:0]};
			OPC_LUI:   res = {w[15:0], 16'h0};
			default:   writes = 1'b0;
		endcase
		if (writes && dst != 0) begin
			regs[dst] = res;
			exp_rd.push_back(dst);
			exp_data.push_back(res);
			exp_seg.push_back(prog_seg[n]);
		end
	end
endtask

task automatic wait_entry(output bit ok);
	int waited;
	waited = 0;
	while (got_rd.size() == 0 && waited < ENTRY_TIMEOUT) begin
		@(negedge clk);
		waited++;
	end
	ok = (got_rd.size() != 0);
endtask

// trace collection, lane 0 is the older one
always @(posedge clk) begin
	if (rst) begin
		compare_value("ibus_read", 32'(ibus_read), 32'h0);
		compare_value("debug_wb_valid", 32'(debug_wb_valid), 32'h0);
	end else begin
		// one pair further per completed access
		if (ibus_read && !ibus_stall) begin
			compare_value("ibus_address", ibus_address, fetch_addr_exp);
			fetch_addr_exp = fetch_addr_exp + 32'd8;
		end
		for (int i = 0; i < `ISSUE_NUM; i++) begin
			if (debug_wb_valid[i]) begin
				got_rd.push_back(debug_wb_waddr[i]);
				got_data.push_back(debug_wb_wdata[i]);
			end
		end
	end
end

initial begin
	checks   = 0;
	errors   = 0;
	next_exp = 0;
	aborted  = 1'b0;
	load_program();
	build_expected();
	for (int i = 0; i < 2*MEM_PAIRS; i++)
		imem[i] = (i < prog_word.size()) ? prog_word[i] : 32'h0;
	for (int i = prog_word.size() - 1; i >= 0; i--)
		if (prog_seg[i] == NUM_SEG - 1)
			stall_from = virt_t'(4*i) & ~32'h7;

	repeat (5) @(posedge clk);
	rst <= 1'b0;

	for (int s = 0; s < NUM_SEG; s++) begin
		seg_errors = errors;
		seg_count  = 0;
		while (!aborted && next_exp < exp_rd.size() && exp_seg[next_exp] == s) begin
			wait_entry(found);
			if (!found) begin
				$display("timeout: no trace entry within %0d cycles in segment %0d after %0d writes",
					ENTRY_TIMEOUT, s, seg_count);
				errors++;
				aborted = 1'b1;
			end else begin
				compare_value("debug_wb_waddr", 32'(got_rd.pop_front()), 32'(exp_rd[next_exp]));
				compare_value("debug_wb_wdata", got_data.pop_front(), exp_data[next_exp]);
				next_exp++;
				seg_count++;
			end
		end
		$display("segment %0d (%s): %0d writes checked, %0d errors", s, seg_name[s],
			seg_count, errors - seg_errors);
	end

	if (!aborted) begin
		for (int c = 0; c < DRAIN_CYCLES; c++)
			@(negedge clk);
		if (got_rd.size() != 0) begin
			$display("trace showed %0d more writes than the program makes", got_rd.size());
			errors++;
		end
	end

	$display("checks %0d, errors %0d", checks, errors);
	if (errors == 0)
		$display("Testbench passed");
	else
		$display("Testbench failed");
	$finish;
end

endmodule
